/* verilog/alloc_pkg.sv */
package alloc_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int DISP_SIZE  = 2;
  localparam int BR_TAG_NUM = 4;
  localparam int BR_TAG_W   = $clog2(BR_TAG_NUM);
  // wide enough for up to four ALU queues
  localparam int ALU_PORT_W = 2;

  typedef logic [BR_TAG_W-1:0]   br_tag_t;
  typedef logic [BR_TAG_NUM-1:0] br_mask_t;

  typedef enum logic [2:0] {
    CAT_ALU,
    CAT_LD,
    CAT_ST,
    CAT_BR,
    CAT_OTHER
  } inst_cat_e;

  // ----------------------------------------
  // dispatch group
  // ----------------------------------------
  typedef struct packed {
    logic                  valid;
    inst_cat_e             cat;
    logic [ALU_PORT_W-1:0] alu_port;
  } disp_slot_t;

  typedef struct packed {
    logic                            valid;
    disp_slot_t [DISP_SIZE-1:0]      slot;
  } disp_grp_t;

  // branch resolution from the BRU
  typedef struct packed {
    logic     update;
    logic     dead;
    logic     mispredict;
    br_tag_t  brtag;
    br_mask_t br_mask;
  } br_upd_t;

  // commit pulse, one entry per retiring slot
  typedef struct packed {
    logic                      commit;
    logic                      flush;
    logic [DISP_SIZE-1:0]      is_br;
    br_tag_t [DISP_SIZE-1:0]   brtag;
  } commit_t;

  function automatic logic is_commit_flush(commit_t c);
    return c.commit & c.flush;
  endfunction

  function automatic logic is_br_flush(br_upd_t u);
    return u.update & ~u.dead & u.mispredict;
  endfunction

  // tag pointer step, wraps at BR_TAG_NUM
  function automatic br_tag_t next_brtag(br_tag_t t);
    return (t == br_tag_t'(BR_TAG_NUM - 1)) ? '0 : t + 1'b1;
  endfunction

endpackage

/* verilog/credit_counter.sv */
module credit_counter #(
  parameter int  MAX_CREDITS = 8,
  parameter int  LOW_MARK    = 2,
  localparam int CNT_W       = $clog2(MAX_CREDITS + 1)
) (
  input  logic             i_clk,
  input  logic             i_reset_n,

  input  logic             i_get,
  input  logic [CNT_W-1:0] i_get_cnt,

  input  logic             i_ret_valid,
  input  logic [CNT_W-1:0] i_ret_cnt,

  output logic [CNT_W-1:0] o_free,
  output logic             o_low
);

  // entries currently held by dispatched instructions
  logic [CNT_W-1:0] r_used;
  logic [CNT_W-1:0] w_add;
  logic [CNT_W-1:0] w_sub;
  // one extra bit so the bound check cannot wrap
  logic [CNT_W:0]   w_avail;

  assign w_add   = i_get       ? i_get_cnt : '0;
  assign w_sub   = i_ret_valid ? i_ret_cnt : '0;
  assign w_avail = r_used + w_add;

  // get and return of one cycle both land here
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_used <= '0;
    end else begin
      r_used <= r_used + w_add - w_sub;
    end
  end

  assign o_free = CNT_W'(MAX_CREDITS) - r_used;
  assign o_low  = (o_free < CNT_W'(LOW_MARK));

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_used_max : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    r_used <= CNT_W'(MAX_CREDITS)
  ) else $error("credit pool over-reserved");

  // back end never frees more than it was given
  a_ret_bound : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_ret_valid |-> ({1'b0, i_ret_cnt} <= w_avail)
  ) else $error("credit return exceeds held entries");

endmodule

/* verilog/branch_tag_alloc.sv */
module branch_tag_alloc (
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  logic                i_fire,
  input  alloc_pkg::disp_grp_t i_disp,

  input  alloc_pkg::br_upd_t  i_br_upd,
  input  alloc_pkg::commit_t  i_commit,

  output alloc_pkg::br_tag_t  o_brtag  [alloc_pkg::DISP_SIZE],
  output alloc_pkg::br_mask_t o_brmask [alloc_pkg::DISP_SIZE]
);

  import alloc_pkg::*;

  logic                 w_commit_flush;

  br_mask_t             r_live;
  br_tag_t              r_ptr;

  // live mask after this cycle's frees and kills
  br_mask_t             w_live_clr;

  logic [DISP_SIZE-1:0] w_is_br;
  br_tag_t              w_tag_chain [DISP_SIZE+1];
  br_mask_t             w_set_chain [DISP_SIZE+1];

  assign w_commit_flush = is_commit_flush(i_commit);

  // ----------------------------------------
  // free and kill
  // ----------------------------------------
  always_comb begin
    w_live_clr = r_live;
    for (int b = 0; b < BR_TAG_NUM; b++) begin
      // committed branches give back their tag
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_commit.commit & i_commit.is_br[d] &
            (i_commit.brtag[d] == br_tag_t'(b))) begin
          w_live_clr[b] = 1'b0;
        end
      end
      if (i_br_upd.update & (i_br_upd.brtag == br_tag_t'(b))) begin
        w_live_clr[b] = 1'b0;
      end
      // mispredict drops everything younger
      if (i_br_upd.update & i_br_upd.mispredict & !i_br_upd.br_mask[b]) begin
        w_live_clr[b] = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // group chaining
  // ----------------------------------------
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_is_br[d] = i_fire & i_disp.slot[d].valid & (i_disp.slot[d].cat == CAT_BR);
    end
  end

  always_comb begin
    w_tag_chain[0] = r_ptr;
    w_set_chain[0] = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (w_is_br[d]) begin
        w_set_chain[d+1] = w_set_chain[d] | (br_mask_t'(1) << w_tag_chain[d]);
        w_tag_chain[d+1] = next_brtag(w_tag_chain[d]);
      end else begin
        w_set_chain[d+1] = w_set_chain[d];
        w_tag_chain[d+1] = w_tag_chain[d];
      end
    end
  end

  // slot d sees the registered mask plus the branches ahead of it
  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_slot_out
    assign o_brtag[d]  = w_tag_chain[d];
    assign o_brmask[d] = r_live | w_set_chain[d];

    a_tag_not_live : assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      w_is_br[d] |-> !w_live_clr[w_tag_chain[d]]
    ) else $error("branch tag handed out while still live");
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_live <= '0;
      r_ptr  <= '0;
    end else begin
      if (w_commit_flush) begin
        // pointer keeps its place across a flush
        r_live <= '0;
      end else begin
        r_live <= w_live_clr | w_set_chain[DISP_SIZE];
        r_ptr  <= w_tag_chain[DISP_SIZE];
      end
    end
  end

endmodule

/* verilog/resource_alloc.sv */
module resource_alloc #(
  parameter int ALU_NUM    = 2,
  parameter int ROB_SIZE   = 16,
  parameter int ALU_Q_SIZE = 8,
  parameter int LDQ_SIZE   = 6,
  parameter int STQ_SIZE   = 6
) (
  input  logic                                         i_clk,
  input  logic                                         i_reset_n,

  input  alloc_pkg::disp_grp_t                         i_disp,
  input  logic                                         i_disp_ready,

  input  alloc_pkg::br_upd_t                           i_br_upd,
  input  alloc_pkg::commit_t                           i_commit,

  // ----------------------------------------
  // credit returns
  // ----------------------------------------
  input  logic                                         i_rob_ret_valid,
  input  logic [$clog2(ROB_SIZE+1)-1:0]                i_rob_ret_cnt,
  input  logic [ALU_NUM-1:0]                           i_alu_ret_valid,
  input  logic [$clog2(ALU_Q_SIZE+1)-1:0]              i_alu_ret_cnt [ALU_NUM],
  input  logic                                         i_ldq_ret_valid,
  input  logic [$clog2(LDQ_SIZE+1)-1:0]                i_ldq_ret_cnt,
  input  logic                                         i_stq_ret_valid,
  input  logic [$clog2(STQ_SIZE+1)-1:0]                i_stq_ret_cnt,
  input  logic                                         i_bru_ret_valid,
  input  logic [$clog2(alloc_pkg::BR_TAG_NUM+1)-1:0]   i_bru_ret_cnt,

  output logic                                         o_resource_ok,
  output alloc_pkg::br_tag_t                           o_brtag  [alloc_pkg::DISP_SIZE],
  output alloc_pkg::br_mask_t                          o_brmask [alloc_pkg::DISP_SIZE]
);

  import alloc_pkg::*;

  localparam int ROB_CW = $clog2(ROB_SIZE + 1);
  localparam int ALU_CW = $clog2(ALU_Q_SIZE + 1);
  localparam int LDQ_CW = $clog2(LDQ_SIZE + 1);
  localparam int STQ_CW = $clog2(STQ_SIZE + 1);
  localparam int BRU_CW = $clog2(BR_TAG_NUM + 1);
  localparam int DEM_W  = $clog2(DISP_SIZE + 1);

  logic               w_flush;
  logic               w_fire;

  // per-pool demand of the offered group
  logic [DEM_W-1:0]   w_rob_dem;
  logic [DEM_W-1:0]   w_ld_dem;
  logic [DEM_W-1:0]   w_st_dem;
  logic [DEM_W-1:0]   w_br_dem;
  logic [DEM_W-1:0]   w_alu_dem [ALU_NUM];

  logic               w_rob_low;
  logic [ALU_NUM-1:0] w_alu_low;
  logic               w_ldq_low;
  logic               w_stq_low;
  logic               w_bru_low;

  assign w_flush = is_commit_flush(i_commit) | is_br_flush(i_br_upd);
  assign w_fire  = ~w_flush & i_disp.valid & i_disp_ready;

  always_comb begin
    w_rob_dem = '0;
    w_ld_dem  = '0;
    w_st_dem  = '0;
    w_br_dem  = '0;
    for (int a = 0; a < ALU_NUM; a++) begin
      w_alu_dem[a] = '0;
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (i_disp.slot[d].valid) begin
        // every valid slot takes a ROB entry
        w_rob_dem = w_rob_dem + 1'b1;
        case (i_disp.slot[d].cat)
          CAT_ALU: begin
            for (int a = 0; a < ALU_NUM; a++) begin
              if (i_disp.slot[d].alu_port == ALU_PORT_W'(a)) begin
                w_alu_dem[a] = w_alu_dem[a] + 1'b1;
              end
            end
          end
          CAT_LD:  w_ld_dem = w_ld_dem + 1'b1;
          CAT_ST:  w_st_dem = w_st_dem + 1'b1;
          CAT_BR:  w_br_dem = w_br_dem + 1'b1;
          default: ;
        endcase
      end
    end
  end

  // ----------------------------------------
  // credit pools
  // ----------------------------------------
  credit_counter #(.MAX_CREDITS(ROB_SIZE), .LOW_MARK(DISP_SIZE)) u_rob_credit (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_get       (w_fire),
    .i_get_cnt   (ROB_CW'(w_rob_dem)),
    .i_ret_valid (i_rob_ret_valid),
    .i_ret_cnt   (i_rob_ret_cnt),
    .o_free      (),
    .o_low       (w_rob_low)
  );

  for (genvar a = 0; a < ALU_NUM; a++) begin : g_alu_credit
    credit_counter #(.MAX_CREDITS(ALU_Q_SIZE), .LOW_MARK(DISP_SIZE)) u_alu_credit (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_get       (w_fire),
      .i_get_cnt   (ALU_CW'(w_alu_dem[a])),
      .i_ret_valid (i_alu_ret_valid[a]),
      .i_ret_cnt   (i_alu_ret_cnt[a]),
      .o_free      (),
      .o_low       (w_alu_low[a])
    );
  end

  credit_counter #(.MAX_CREDITS(LDQ_SIZE), .LOW_MARK(DISP_SIZE)) u_ldq_credit (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_get       (w_fire),
    .i_get_cnt   (LDQ_CW'(w_ld_dem)),
    .i_ret_valid (i_ldq_ret_valid),
    .i_ret_cnt   (i_ldq_ret_cnt),
    .o_free      (),
    .o_low       (w_ldq_low)
  );

  credit_counter #(.MAX_CREDITS(STQ_SIZE), .LOW_MARK(DISP_SIZE)) u_stq_credit (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_get       (w_fire),
    .i_get_cnt   (STQ_CW'(w_st_dem)),
    .i_ret_valid (i_stq_ret_valid),
    .i_ret_cnt   (i_stq_ret_cnt),
    .o_free      (),
    .o_low       (w_stq_low)
  );

  credit_counter #(.MAX_CREDITS(BR_TAG_NUM), .LOW_MARK(DISP_SIZE)) u_bru_credit (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_get       (w_fire),
    .i_get_cnt   (BRU_CW'(w_br_dem)),
    .i_ret_valid (i_bru_ret_valid),
    .i_ret_cnt   (i_bru_ret_cnt),
    .o_free      (),
    .o_low       (w_bru_low)
  );

  assign o_resource_ok = ~(w_rob_low | (|w_alu_low) | w_ldq_low | w_stq_low | w_bru_low);

  branch_tag_alloc u_branch_tag_alloc (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_fire    (w_fire),
    .i_disp    (i_disp),
    .i_br_upd  (i_br_upd),
    .i_commit  (i_commit),
    .o_brtag   (o_brtag),
    .o_brmask  (o_brmask)
  );

  // an ALU slot must name an existing queue, or its credit is lost
  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_port_chk
    a_alu_port : assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      (w_fire & i_disp.slot[d].valid & (i_disp.slot[d].cat == CAT_ALU))
        |-> (int'(i_disp.slot[d].alu_port) < ALU_NUM)
    ) else $error("ALU slot routed to a missing queue");
  end

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 4
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
  end

  always #(PERIOD / 2) o_clk = ~o_clk;

  // reset held low for a few edges, released on a rising edge
  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset_n <= 1'b1;
  end

endmodule

/* sim/resource_alloc_tb.sv */
module resource_alloc_tb;

  import alloc_pkg::*;

  // default sizes of the DUT
  localparam int ALU_NUM    = 2;
  localparam int ROB_SIZE   = 16;
  localparam int ALU_Q_SIZE = 8;
  localparam int LDQ_SIZE   = 6;
  localparam int STQ_SIZE   = 6;
  localparam int ROB_CW     = $clog2(ROB_SIZE + 1);
  localparam int ALU_CW     = $clog2(ALU_Q_SIZE + 1);
  localparam int LDQ_CW     = $clog2(LDQ_SIZE + 1);
  localparam int STQ_CW     = $clog2(STQ_SIZE + 1);
  localparam int BRU_CW     = $clog2(BR_TAG_NUM + 1);

  // pool index in the model
  localparam int P_ROB = 0;
  localparam int P_LDQ = 1;
  localparam int P_STQ = 2;
  localparam int P_BRU = 3;
  localparam int P_ALU = 4;
  localparam int NPOOL = P_ALU + ALU_NUM;

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 4;
  localparam int DIRECTED_CYCLES = 120;
  localparam int RAND_CYCLES     = 400;
  localparam int TIMEOUT = (RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES) * CLK_PERIOD * 2;

  logic                clk;
  logic                reset_n;
  disp_grp_t           disp;
  logic                disp_ready;
  br_upd_t             br_upd;
  commit_t             commit;
  logic                rob_ret_valid;
  logic [ROB_CW-1:0]   rob_ret_cnt;
  logic [ALU_NUM-1:0]  alu_ret_valid;
  logic [ALU_CW-1:0]   alu_ret_cnt [ALU_NUM];
  logic                ldq_ret_valid;
  logic [LDQ_CW-1:0]   ldq_ret_cnt;
  logic                stq_ret_valid;
  logic [STQ_CW-1:0]   stq_ret_cnt;
  logic                bru_ret_valid;
  logic [BRU_CW-1:0]   bru_ret_cnt;
  logic                resource_ok;
  br_tag_t             brtag  [DISP_SIZE];
  br_mask_t            brmask [DISP_SIZE];

  // inputs for the next cycle, driven by tick
  disp_grp_t           nx_disp;
  logic                nx_ready;
  br_upd_t             nx_upd;
  commit_t             nx_commit;
  int                  nx_ret  [NPOOL];
  int                  cur_ret [NPOOL];

  // reference model state
  int                  m_used [NPOOL];
  br_mask_t            m_live;
  br_tag_t             m_ptr;
  br_mask_t            tag_mask [BR_TAG_NUM];

  string               cur_test;
  int                  err_test;
  int                  err_total;
  int                  n_tests;
  int                  n_checks;
  int                  seed = 32'h4431db6d;

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  resource_alloc u_resource_alloc (
    .i_clk           (clk),
    .i_reset_n       (reset_n),
    .i_disp          (disp),
    .i_disp_ready    (disp_ready),
    .i_br_upd        (br_upd),
    .i_commit        (commit),
    .i_rob_ret_valid (rob_ret_valid),
    .i_rob_ret_cnt   (rob_ret_cnt),
    .i_alu_ret_valid (alu_ret_valid),
    .i_alu_ret_cnt   (alu_ret_cnt),
    .i_ldq_ret_valid (ldq_ret_valid),
    .i_ldq_ret_cnt   (ldq_ret_cnt),
    .i_stq_ret_valid (stq_ret_valid),
    .i_stq_ret_cnt   (stq_ret_cnt),
    .i_bru_ret_valid (bru_ret_valid),
    .i_bru_ret_cnt   (bru_ret_cnt),
    .o_resource_ok   (resource_ok),
    .o_brtag         (brtag),
    .o_brmask        (brmask)
  );

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_bit(string what, logic exp, logic act);
    n_checks++;
    if (act !== exp) begin
      err_test++;
      $display("error %s %s: expected %0b, actual %0b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_tag(string what, br_tag_t exp, br_tag_t act);
    n_checks++;
    if (act !== exp) begin
      err_test++;
      $display("error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_mask(string what, br_mask_t exp, br_mask_t act);
    n_checks++;
    if (act !== exp) begin
      err_test++;
      $display("error %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic int pool_max(int p);
    if (p == P_ROB) return ROB_SIZE;
    if (p == P_LDQ) return LDQ_SIZE;
    if (p == P_STQ) return STQ_SIZE;
    if (p == P_BRU) return BR_TAG_NUM;
    return ALU_Q_SIZE;
  endfunction

  // a group of DISP_SIZE is guaranteed to fit
  function automatic logic model_ok();
    for (int p = 0; p < NPOOL; p++) begin
      if (pool_max(p) - m_used[p] < DISP_SIZE) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic model_step();
    logic     flush;
    logic     fire;
    br_mask_t set;
    br_mask_t lc;
    int       p;
    flush = (commit.commit & commit.flush) |
            (br_upd.update & ~br_upd.dead & br_upd.mispredict);
    fire  = disp.valid & disp_ready & ~flush;
    check_bit("resource_ok", model_ok(), resource_ok);
    p   = int'(m_ptr);
    set = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      check_tag($sformatf("brtag[%0d]", d), br_tag_t'(p), brtag[d]);
      check_mask($sformatf("brmask[%0d]", d), m_live | set, brmask[d]);
      if (fire && disp.slot[d].valid && disp.slot[d].cat == CAT_BR) begin
        tag_mask[p] = m_live | set;
        set[p] = 1'b1;
        p = (p + 1) % BR_TAG_NUM;
      end
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (fire && disp.slot[d].valid) begin
        m_used[P_ROB]++;
        case (disp.slot[d].cat)
          CAT_ALU: m_used[P_ALU + int'(disp.slot[d].alu_port)]++;
          CAT_LD:  m_used[P_LDQ]++;
          CAT_ST:  m_used[P_STQ]++;
          CAT_BR:  m_used[P_BRU]++;
          default: ;
        endcase
      end
    end
    for (int q = 0; q < NPOOL; q++) begin
      m_used[q] -= cur_ret[q];
    end
    lc = m_live;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (commit.commit && commit.is_br[d]) lc[commit.brtag[d]] = 1'b0;
    end
    if (br_upd.update) begin
      lc[br_upd.brtag] = 1'b0;
      // younger branches die with a mispredict
      if (br_upd.mispredict) lc = lc & br_upd.br_mask;
    end
    if (commit.commit && commit.flush) begin
      m_live = '0;
    end else begin
      m_live = lc | set;
      m_ptr  = br_tag_t'(p);
    end
  endtask

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------
  task automatic tick();
    @(posedge clk);
    disp          <= nx_disp;
    disp_ready    <= nx_ready;
    br_upd        <= nx_upd;
    commit        <= nx_commit;
    rob_ret_valid <= (nx_ret[P_ROB] != 0);
    rob_ret_cnt   <= ROB_CW'(nx_ret[P_ROB]);
    ldq_ret_valid <= (nx_ret[P_LDQ] != 0);
    ldq_ret_cnt   <= LDQ_CW'(nx_ret[P_LDQ]);
    stq_ret_valid <= (nx_ret[P_STQ] != 0);
    stq_ret_cnt   <= STQ_CW'(nx_ret[P_STQ]);
    bru_ret_valid <= (nx_ret[P_BRU] != 0);
    bru_ret_cnt   <= BRU_CW'(nx_ret[P_BRU]);
    for (int a = 0; a < ALU_NUM; a++) begin
      alu_ret_valid[a] <= (nx_ret[P_ALU + a] != 0);
      alu_ret_cnt[a]   <= ALU_CW'(nx_ret[P_ALU + a]);
    end
    cur_ret   = nx_ret;
    nx_disp   = '0;
    nx_ready  = 1'b0;
    nx_upd    = '0;
    nx_commit = '0;
    for (int q = 0; q < NPOOL; q++) begin
      nx_ret[q] = 0;
    end
    // outputs settle by the falling edge
    @(negedge clk);
    model_step();
  endtask

  function automatic disp_grp_t pair(inst_cat_e c0, int p0, inst_cat_e c1, int p1);
    disp_grp_t g;
    g = '0;
    g.valid = 1'b1;
    g.slot[0].valid    = 1'b1;
    g.slot[0].cat      = c0;
    g.slot[0].alu_port = ALU_PORT_W'(p0);
    g.slot[1].valid    = 1'b1;
    g.slot[1].cat      = c1;
    g.slot[1].alu_port = ALU_PORT_W'(p1);
    return g;
  endfunction

  task automatic send(disp_grp_t g);
    nx_disp  = g;
    nx_ready = 1'b1;
    tick();
  endtask

  task automatic hold(disp_grp_t g);
    nx_disp  = g;
    nx_ready = 1'b0;
    tick();
  endtask

  task automatic resolve(br_tag_t t, logic mp);
    nx_upd.update     = 1'b1;
    nx_upd.mispredict = mp;
    nx_upd.brtag      = t;
    nx_upd.br_mask    = tag_mask[t];
    nx_ret[P_BRU]     = 1;
    tick();
  endtask

  // hand back everything the model says is in use
  task automatic drain();
    for (int q = 0; q < NPOOL; q++) begin
      nx_ret[q] = m_used[q];
    end
    tick();
  endtask

  task automatic fill_check(disp_grp_t g, int n);
    for (int i = 0; i < n; i++) begin
      send(g);
      check_bit("ok while filling", 1'b1, resource_ok);
    end
    tick();
    check_bit("ok after fill", 1'b0, resource_ok);
  endtask

  task automatic begin_test(string name);
    cur_test = name;
    err_test = 0;
  endtask

  task automatic end_test();
    $display("test %-8s done, %0d errors", cur_test, err_test);
    err_total += err_test;
    n_tests++;
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------
  task automatic test_reset();
    begin_test("reset");
    tick();
    check_bit("resource_ok", 1'b1, resource_ok);
    check_tag("brtag[0]", '0, brtag[0]);
    for (int d = 0; d < DISP_SIZE; d++) begin
      check_mask("brmask", '0, brmask[d]);
    end
    end_test();
  endtask

  task automatic test_ldq();
    begin_test("ldq");
    fill_check(pair(CAT_LD, 0, CAT_LD, 0), 3);
    nx_ret[P_LDQ] = 2;
    tick();
    check_bit("ok in return cycle", 1'b0, resource_ok);
    tick();
    check_bit("ok after return", 1'b1, resource_ok);
    // a held group must not reserve
    repeat (3) begin
      hold(pair(CAT_LD, 0, CAT_LD, 0));
      check_bit("ok while held", 1'b1, resource_ok);
    end
    tick();
    check_bit("ok after hold", 1'b1, resource_ok);
    drain();
    end_test();
  endtask

  task automatic test_pools();
    begin_test("pools");
    fill_check(pair(CAT_OTHER, 0, CAT_OTHER, 0), 8);
    drain();
    fill_check(pair(CAT_ST, 0, CAT_ST, 0), 3);
    nx_ret[P_STQ] = 2;
    send(pair(CAT_OTHER, 0, CAT_ALU, 0));
    check_bit("ok with get and return", 1'b0, resource_ok);
    tick();
    check_bit("ok after get and return", 1'b1, resource_ok);
    drain();
    for (int a = 0; a < ALU_NUM; a++) begin
      fill_check(pair(CAT_ALU, a, CAT_ALU, a), 4);
      // a return on the same port reopens that queue
      nx_ret[P_ALU + a] = 2;
      tick();
      tick();
      check_bit("ok after alu return", 1'b1, resource_ok);
      drain();
    end
    end_test();
  endtask

  task automatic test_tags();
    begin_test("tags");
    send(pair(CAT_BR, 0, CAT_BR, 0));
    check_tag("slot0 tag", 2'd0, brtag[0]);
    check_tag("slot1 tag", 2'd1, brtag[1]);
    check_mask("slot0 mask", 4'b0000, brmask[0]);
    check_mask("slot1 mask", 4'b0001, brmask[1]);
    tick();
    check_mask("live after fire", 4'b0011, brmask[0]);
    resolve(2'd0, 1'b0);
    resolve(2'd1, 1'b0);
    send(pair(CAT_BR, 0, CAT_BR, 0));
    check_tag("slot0 tag", 2'd2, brtag[0]);
    check_tag("slot1 tag", 2'd3, brtag[1]);
    resolve(2'd2, 1'b0);
    resolve(2'd3, 1'b0);
    send(pair(CAT_BR, 0, CAT_OTHER, 0));
    check_tag("wrapped tag", 2'd0, brtag[0]);
    resolve(2'd0, 1'b0);
    tick();
    check_mask("live after resolve", 4'b0000, brmask[0]);
    drain();
    end_test();
  endtask

  task automatic test_kill();
    begin_test("kill");
    // tags 1 and 2, then 3
    send(pair(CAT_BR, 0, CAT_BR, 0));
    send(pair(CAT_BR, 0, CAT_OTHER, 0));
    resolve(2'd2, 1'b1);
    tick();
    check_mask("live after mispredict", 4'b0010, brmask[0]);
    nx_commit.commit   = 1'b1;
    nx_commit.is_br[0] = 1'b1;
    nx_commit.brtag[0] = 2'd1;
    tick();
    tick();
    check_mask("live after commit", 4'b0000, brmask[0]);
    drain();
    send(pair(CAT_LD, 0, CAT_LD, 0));
    send(pair(CAT_LD, 0, CAT_LD, 0));
    send(pair(CAT_BR, 0, CAT_BR, 0));
    nx_commit.commit = 1'b1;
    nx_commit.flush  = 1'b1;
    send(pair(CAT_LD, 0, CAT_LD, 0));
    tick();
    check_bit("ok after flushed group", 1'b1, resource_ok);
    check_mask("slot0 mask after flush", 4'b0000, brmask[0]);
    check_mask("slot1 mask after flush", 4'b0000, brmask[1]);
    check_tag("pointer held", 2'd2, brtag[0]);
    drain();
    end_test();
  endtask

  function automatic int urand(int n);
    return int'(($random(seed) & 32'h7fff_ffff) % n);
  endfunction

  task automatic test_random();
    int p;
    int r;
    int t;
    begin_test("random");
    for (int i = 0; i < RAND_CYCLES; i++) begin
      nx_disp.valid = (urand(8) != 0);
      for (int d = 0; d < DISP_SIZE; d++) begin
        nx_disp.slot[d].valid    = (urand(4) != 0);
        nx_disp.slot[d].cat      = inst_cat_e'(urand(5));
        nx_disp.slot[d].alu_port = ALU_PORT_W'(urand(ALU_NUM));
      end
      nx_ready = model_ok() && (urand(4) != 0);
      // a branch whose tag is still live becomes a plain op
      p = int'(m_ptr);
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (nx_disp.slot[d].valid && nx_disp.slot[d].cat == CAT_BR) begin
          if (m_live[p]) nx_disp.slot[d].cat = CAT_OTHER;
          else p = (p + 1) % BR_TAG_NUM;
        end
      end
      for (int q = 0; q < NPOOL; q++) begin
        if (urand(4) == 0) nx_ret[q] = urand(m_used[q] + 1);
      end
      r = urand(16);
      t = urand(BR_TAG_NUM);
      if (r == 0) begin
        nx_commit.commit = 1'b1;
        nx_commit.flush  = 1'b1;
      end else if (r <= 3 && m_live[t]) begin
        nx_upd.update     = 1'b1;
        nx_upd.mispredict = (r == 1);
        nx_upd.brtag      = br_tag_t'(t);
        nx_upd.br_mask    = tag_mask[t];
      end else if (r <= 5 && m_live[t]) begin
        nx_commit.commit   = 1'b1;
        nx_commit.is_br[0] = 1'b1;
        nx_commit.brtag[0] = br_tag_t'(t);
      end
      tick();
    end
    drain();
    end_test();
  endtask

  initial begin
    #(TIMEOUT);
    $display("timeout: run did not finish within %0d time units", TIMEOUT);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    disp          = '0;
    disp_ready    = 1'b0;
    br_upd        = '0;
    commit        = '0;
    rob_ret_valid = 1'b0;
    rob_ret_cnt   = '0;
    alu_ret_valid = '0;
    ldq_ret_valid = 1'b0;
    ldq_ret_cnt   = '0;
    stq_ret_valid = 1'b0;
    stq_ret_cnt   = '0;
    bru_ret_valid = 1'b0;
    bru_ret_cnt   = '0;
    for (int a = 0; a < ALU_NUM; a++) begin
      alu_ret_cnt[a] = '0;
    end
    nx_disp   = '0;
    nx_ready  = 1'b0;
    nx_upd    = '0;
    nx_commit = '0;
    for (int q = 0; q < NPOOL; q++) begin
      nx_ret[q]  = 0;
      cur_ret[q] = 0;
      m_used[q]  = 0;
    end
    for (int b = 0; b < BR_TAG_NUM; b++) begin
      tag_mask[b] = '0;
    end
    m_live    = '0;
    m_ptr     = '0;
    err_total = 0;
    n_tests   = 0;
    n_checks  = 0;
    wait (reset_n === 1'b1);
    test_reset();
    test_ldq();
    test_pools();
    test_tags();
    test_kill();
    test_random();
    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, err_total);
    if (err_total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* all.f */
verilog/alloc_pkg.sv
verilog/credit_counter.sv
verilog/branch_tag_alloc.sv
verilog/resource_alloc.sv
sim/tb_clock_gen.sv
sim/resource_alloc_tb.sv

/* Makefile */
TOP := resource_alloc_tb
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
	  echo "FAIL: testbench reported errors"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
	  echo "FAIL: run ended without a result"; exit 1; \
	else \
	  echo "PASS"; \
	fi

lint:
	verilator --lint-only -Wall --timing --top-module resource_alloc -f all.f

clean:
	rm -rf obj_dir $(LOG)
